//--- bench/osd_ctrl_stim.hex
// opcode address data expected, one record per line
// opcodes 01 write, 02 read, 03 ram check, 04 mode check, 05 pulse check, 00 end
02 0082 00 000000FF
01 0081 01 00000000
02 0081 00 00000001
01 0082 05 00000000
02 0082 00 00000005
01 0084 3C 00000000
02 0084 00 0000003C
01 0088 80 00000000
02 0088 00 00000080
01 0089 D5 00000000
02 0089 00 000000D0
01 0090 2A 00000000
02 0090 00 0000002A
01 0080 02 00000000
01 0015 A7 00000000
03 0115 00 000000A7
04 0000 00 00780438
01 0083 01 00000000
04 0000 00 105003C0
01 0083 12 00000000
04 0000 00 612D01E0
01 0083 23 00000000
04 0000 00 802D01E0
01 0083 40 00000000
04 0000 00 902D0240
01 0083 7F 00000000
04 0000 00 902D0240
05 00F0 01 00000008
05 00F1 01 00000008
05 00F2 5A 0000005A
02 0085 00 000000D2
02 0086 00 000000D9
02 0087 00 000000A0
02 00B0 00 0000003F
02 00B1 00 000000A5
02 00B2 00 0000003C
02 00B3 00 00000012
02 00B4 00 00000034
02 00B5 00 00000056
02 00B6 00 000000C0
02 00B7 00 00000080
02 00B8 00 00000040
02 00A0 00 00000000
00 0000 00 00000000

//--- verilog.f
rtl/osd_reg_pkg.sv
rtl/video_mode_pkg.sv
rtl/wb_reg_bridge.sv
rtl/osd_reg_file.sv
rtl/osd_char_ram.sv
rtl/video_mode_table.sv
rtl/osd_ctrl_top.sv
bench/osd_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the OSD control testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=osd_ctrl_sim
LOG=sim.log

verilator --binary --timing -j 0 -f verilog.f --top-module osd_ctrl_tb \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    echo "failures reported in $LOG"
    exit 1
fi

echo "simulation clean, log in $LOG"
exit 0

//--- bench/osd_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module osd_ctrl_tb;

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 10;
    localparam int MAX_RECORDS = 64;
    // cycles a bus cycle may wait for ack
    localparam int ACK_LIMIT = 16;
    // watchdog budget per record
    localparam int CYCLES_PER_RECORD = 20;

    typedef enum logic [7:0] {
        END_OF_LIST = 8'h00,
        BUS_WRITE   = 8'h01,
        BUS_READ    = 8'h02,
        RAM_CHECK   = 8'h03,
        MODE_CHECK  = 8'h04,
        PULSE_CHECK = 8'h05
    } op_e;

    logic        clk;
    logic        rst_n;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [7:0]  adr;
    logic [7:0]  dat_w;
    logic [7:0]  dat_r;
    logic        ack;
    logic [12:0] ctrl_buttons;
    logic        ctrl_valid;
    logic        add_line;
    logic        line_doubler;
    logic        is_pal;
    logic [23:0] pinok;
    logic [23:0] timing_info;
    logic [23:0] rgb_data;
    logic [9:0]  osd_rd_addr;
    logic [7:0]  osd_rd_data;
    logic        osd_enable;
    logic [7:0]  highlight_line;
    logic [7:0]  video_gen_data;
    logic [8:0]  scan_intensity;
    logic        scan_thickness;
    logic        scan_oddeven;
    logic        scan_active;
    logic [7:0]  conf240p;
    logic        reset_dc;
    logic        reset_opt;
    logic [7:0]  reset_conf;
    logic [11:0] h_active;
    logic [10:0] v_active;
    logic        line_double;
    video_mode_pkg::video_mode_e video_mode;

    // four words per record, opcode, address, data, expected
    logic [31:0] stim_mem [0:4*MAX_RECORDS-1];
    int          num_records;
    int          pass_count;
    int          fail_count;
    logic        stim_loaded = 1'b0;

    osd_ctrl_top dut (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // bus and observation helpers
    ////////////////////////////////////////////////////////////////////////////

    // one wishbone classic cycle, driven on falling edges
    task automatic bus_cycle(input logic write, input logic [7:0] addr,
                             input logic [7:0] wdata, output logic [7:0] rdata,
                             output logic got_ack);
        int waited;
        waited  = 0;
        got_ack = 1'b0;
        rdata   = '0;
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        dat_w = wdata;
        while (!got_ack && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
            if (ack) begin
                got_ack = 1'b1;
                rdata   = dat_r;
            end
        end
        // stb must drop after ack or the request repeats
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    // control output ports packed like their register
    function automatic logic [7:0] port_byte(input logic [7:0] addr);
        case (addr)
            8'h81:   return {7'b0, osd_enable};
            8'h82:   return highlight_line;
            8'h84:   return video_gen_data;
            8'h88:   return scan_intensity[8:1];
            8'h89: begin
                return {scan_intensity[0], scan_thickness, scan_oddeven,
                        scan_active, 4'b0};
            end
            8'h90:   return conf240p;
            default: return 8'h00;
        endcase
    endfunction

    // registers that also leave the top level as ports
    function automatic logic has_port(input logic [7:0] addr);
        return addr inside {8'h81, 8'h82, 8'h84, 8'h88, 8'h89, 8'h90};
    endfunction

    // pulse output tied to a reset address
    function automatic logic watched_pulse(input logic [7:0] addr);
        if (addr == 8'hF0) begin
            return reset_dc;
        end
        if (addr == 8'hF1) begin
            return reset_opt;
        end
        return 1'b0;
    endfunction

    // write and record the pulse over five falling edges, msb first
    task automatic pulse_write(input logic [7:0] addr, input logic [7:0] wdata,
                               output logic [7:0] seen, output logic got_ack);
        got_ack = 1'b0;
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = addr;
        dat_w = wdata;
        seen  = {7'b0, watched_pulse(addr)};
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            if (ack) begin
                got_ack = 1'b1;
                cyc = 1'b0;
                stb = 1'b0;
                we  = 1'b0;
            end
            seen = {seen[6:0], watched_pulse(addr)};
        end
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        // reset config is a held value, not a pulse
        if (addr == 8'hF2) begin
            seen = reset_conf;
        end
    endtask

    task automatic run_record(input int idx);
        op_e         op;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [31:0] expect_val;
        logic [31:0] got;
        logic [7:0]  rdata;
        logic        got_ack;
        logic        ok;
        video_mode_pkg::video_mode_e exp_mode;
        op         = op_e'(stim_mem[4*idx][7:0]);
        addr       = stim_mem[4*idx+1][15:0];
        data       = stim_mem[4*idx+2][7:0];
        expect_val = stim_mem[4*idx+3];
        got        = '0;
        ok         = 1'b1;
        case (op)
            BUS_WRITE, BUS_READ: begin
                bus_cycle(op == BUS_WRITE, addr[7:0], data, rdata, got_ack);
                got = {24'h0, rdata};
                if (!got_ack) begin
                    $display("record %0d: no ack on the bus after %0d cycles", idx, ACK_LIMIT);
                    ok = 1'b0;
                end else if (op == BUS_READ && got != expect_val) begin
                    $display("Mismatch at %0t: read 0x%02h got 0x%02h expected 0x%02h",
                             $time, addr[7:0], rdata, expect_val[7:0]);
                    ok = 1'b0;
                end else if (op == BUS_READ && has_port(addr[7:0])
                             && {24'h0, port_byte(addr[7:0])} != expect_val) begin
                    $display("Mismatch at %0t: port for 0x%02h holds 0x%02h expected 0x%02h",
                             $time, addr[7:0], port_byte(addr[7:0]), expect_val[7:0]);
                    ok = 1'b0;
                end
            end
            // display port, one cycle read latency
            RAM_CHECK: begin
                @(negedge clk);
                osd_rd_addr = addr[9:0];
                @(negedge clk);
                got = {24'h0, osd_rd_data};
                if (got != expect_val) begin
                    $display("Mismatch at %0t: ram 0x%03h got 0x%02h expected 0x%02h",
                             $time, addr[9:0], osd_rd_data, expect_val[7:0]);
                    ok = 1'b0;
                end
            end
            // mode, line double, h and v packed as in the stim file
            MODE_CHECK: begin
                @(negedge clk);
                got      = {video_mode, 3'b0, line_double, h_active, 1'b0, v_active};
                exp_mode = video_mode_pkg::video_mode_e'(expect_val[31:28]);
                if (got != expect_val) begin
                    $display("Mismatch at %0t: mode %s 0x%08h expected %s 0x%08h",
                             $time, video_mode.name(), got, exp_mode.name(), expect_val);
                    ok = 1'b0;
                end
            end
            PULSE_CHECK: begin
                pulse_write(addr[7:0], data, rdata, got_ack);
                got = {24'h0, rdata};
                if (!got_ack) begin
                    $display("record %0d: no ack on the bus after a reset write", idx);
                    ok = 1'b0;
                end else if (got != expect_val) begin
                    $display("Mismatch at %0t: output for 0x%02h got 0x%02h expected 0x%02h",
                             $time, addr[7:0], rdata, expect_val[7:0]);
                    ok = 1'b0;
                end
            end
            default: begin
                $display("record %0d: unknown opcode 0x%02h in the stim file", idx, op);
                ok = 1'b0;
            end
        endcase
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("record %0d %s addr 0x%04h data 0x%02h: %s",
                 idx, op.name(), addr, data, ok ? "ok" : "error");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rst_n       = 1'b0;
        cyc         = 1'b0;
        stb         = 1'b0;
        we          = 1'b0;
        adr         = '0;
        dat_w       = '0;
        osd_rd_addr = '0;
        // fixed status inputs
        ctrl_buttons = 13'h1A5B;
        ctrl_valid   = 1'b1;
        add_line     = 1'b1;
        line_doubler = 1'b0;
        is_pal       = 1'b1;
        pinok        = 24'hFFA53C;
        timing_info  = 24'h123456;
        rgb_data     = 24'hC08040;
        pass_count   = 0;
        fail_count   = 0;
        for (int i = 0; i < 4*MAX_RECORDS; i++) begin
            stim_mem[i] = '0;
        end
        $readmemh("bench/osd_ctrl_stim.hex", stim_mem);
        // list ends at the first zero opcode
        num_records = 0;
        while (num_records < MAX_RECORDS && stim_mem[4*num_records] != 32'h0) begin
            num_records++;
        end
        stim_loaded = 1'b1;
        if (num_records == 0) begin
            $display("stim file is missing or holds no records");
            fail_count++;
        end
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < num_records; i++) begin
            run_record(i);
        end
        $display("%0d records, %0d passed, %0d failed", num_records, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog, sized from the record count
    initial begin
        wait (stim_loaded);
        #((num_records * CYCLES_PER_RECORD + RST_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before all records finished");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/osd_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module osd_ctrl_top (
    input  logic                                    clk,
    input  logic                                    rst_n,
    // wishbone classic slave
    input  logic                                    cyc,
    input  logic                                    stb,
    input  logic                                    we,
    input  logic [osd_reg_pkg::ADDR_W-1:0]          adr,
    input  logic [osd_reg_pkg::DATA_W-1:0]          dat_w,
    output logic [osd_reg_pkg::DATA_W-1:0]          dat_r,
    output logic                                    ack,
    // live status
    input  logic [12:0]                             ctrl_buttons,
    input  logic                                    ctrl_valid,
    input  logic                                    add_line,
    input  logic                                    line_doubler,
    input  logic                                    is_pal,
    input  logic [23:0]                             pinok,
    input  logic [23:0]                             timing_info,
    input  logic [23:0]                             rgb_data,
    // display read port
    input  logic [osd_reg_pkg::RAM_ADDR_W-1:0]      osd_rd_addr,
    output logic [osd_reg_pkg::DATA_W-1:0]          osd_rd_data,
    // control outputs
    output logic                                    osd_enable,
    output logic [7:0]                              highlight_line,
    output logic [7:0]                              video_gen_data,
    output logic [8:0]                              scan_intensity,
    output logic                                    scan_thickness,
    output logic                                    scan_oddeven,
    output logic                                    scan_active,
    output logic [7:0]                              conf240p,
    output logic                                    reset_dc,
    output logic                                    reset_opt,
    output logic [7:0]                              reset_conf,
    // mode
    output video_mode_pkg::video_mode_e             video_mode,
    output logic [video_mode_pkg::H_ACTIVE_W-1:0]   h_active,
    output logic [video_mode_pkg::V_ACTIVE_W-1:0]   v_active,
    output logic                                    line_double
);

    logic [osd_reg_pkg::ADDR_W-1:0]      reg_addr;
    logic [osd_reg_pkg::DATA_W-1:0]      reg_wdata;
    logic [osd_reg_pkg::DATA_W-1:0]      rd_data;
    logic                                wr_strobe;
    logic                                rd_strobe;
    logic [osd_reg_pkg::RAM_ADDR_W-1:0]  ram_waddr;
    logic [osd_reg_pkg::DATA_W-1:0]      ram_wdata;
    logic                                ram_we;
    logic [osd_reg_pkg::RECONF_W-1:0]    reconf_code;
    logic                                reconf_load;

    wb_reg_bridge u_bridge (
        .clk, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .rd_data,
        .ack, .dat_r, .reg_addr, .reg_wdata, .wr_strobe, .rd_strobe
    );

    osd_reg_file u_regs (
        .clk, .rst_n, .reg_addr, .reg_wdata, .wr_strobe, .rd_strobe,
        .ctrl_buttons, .ctrl_valid, .add_line, .line_doubler, .is_pal,
        .pinok, .timing_info, .rgb_data,
        .rd_data, .ram_waddr, .ram_wdata, .ram_we,
        .osd_enable, .highlight_line, .reconf_code, .reconf_load, .video_gen_data,
        .scan_intensity, .scan_thickness, .scan_oddeven, .scan_active,
        .conf240p, .reset_dc, .reset_opt, .reset_conf
    );

    osd_char_ram u_char_ram (
        .clk, .ram_waddr, .ram_wdata, .ram_we, .osd_rd_addr, .osd_rd_data
    );

    video_mode_table u_mode_table (
        .clk, .rst_n, .reconf_code, .reconf_load,
        .video_mode, .h_active, .v_active, .line_double
    );

endmodule

`default_nettype wire

//--- rtl/video_mode_table.sv
`timescale 1ns/1ps
`default_nettype none

module video_mode_table (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [osd_reg_pkg::RECONF_W-1:0]        reconf_code,
    input  logic                                    reconf_load,
    output video_mode_pkg::video_mode_e             video_mode,
    output logic [video_mode_pkg::H_ACTIVE_W-1:0]   h_active,
    output logic [video_mode_pkg::V_ACTIVE_W-1:0]   v_active,
    output logic                                    line_double
);

    video_mode_pkg::video_mode_e              next_mode;
    logic                                     code_hit;
    logic [video_mode_pkg::H_ACTIVE_W-1:0]    next_h;
    logic [video_mode_pkg::V_ACTIVE_W-1:0]    next_v;

    // group match
    always_comb begin
        next_mode = video_mode;
        code_hit  = 1'b1;
        if (reconf_code[6:2] == video_mode_pkg::CODE_GRP_480P[6:2]) begin
            // low bits index 1080p, 960p, 480p, vga
            next_mode = video_mode_pkg::video_mode_e'({2'b00, reconf_code[1:0]});
        end else if (reconf_code[6:2] == video_mode_pkg::CODE_GRP_240P[6:2]) begin
            next_mode = video_mode_pkg::video_mode_e'({2'b01, reconf_code[1:0]});
        end else if (reconf_code[6:4] == video_mode_pkg::CODE_GRP_480I[6:4]) begin
            next_mode = video_mode_pkg::MODE_480I;
        end else if (reconf_code[6:4] == video_mode_pkg::CODE_GRP_576I[6:4]) begin
            next_mode = video_mode_pkg::MODE_576I;
        end else begin
            // unknown code, keep the current mode
            code_hit = 1'b0;
        end
    end

    // timing lookup, 240p variants scale to the same output area
    always_comb begin
        case (next_mode)
            video_mode_pkg::MODE_960P, video_mode_pkg::MODE_240P_960P: begin
                next_h = video_mode_pkg::H_960P;
                next_v = video_mode_pkg::V_960P;
            end
            video_mode_pkg::MODE_480P, video_mode_pkg::MODE_240P_480P: begin
                next_h = video_mode_pkg::H_480P;
                next_v = video_mode_pkg::V_480P;
            end
            video_mode_pkg::MODE_VGA, video_mode_pkg::MODE_240P_VGA: begin
                next_h = video_mode_pkg::H_VGA;
                next_v = video_mode_pkg::V_VGA;
            end
            video_mode_pkg::MODE_480I: begin
                next_h = video_mode_pkg::H_480I;
                next_v = video_mode_pkg::V_480I;
            end
            video_mode_pkg::MODE_576I: begin
                next_h = video_mode_pkg::H_576I;
                next_v = video_mode_pkg::V_576I;
            end
            default: begin
                next_h = video_mode_pkg::H_1080P;
                next_v = video_mode_pkg::V_1080P;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            video_mode  <= video_mode_pkg::MODE_1080P;
            h_active    <= video_mode_pkg::H_1080P;
            v_active    <= video_mode_pkg::V_1080P;
            line_double <= 1'b0;
        end else if (reconf_load && code_hit) begin
            video_mode  <= next_mode;
            h_active    <= next_h;
            v_active    <= next_v;
            // 240p family sits at 4..7
            line_double <= (next_mode[3:2] == 2'b01);
        end
    end

endmodule

`default_nettype wire

//--- rtl/osd_char_ram.sv
`timescale 1ns/1ps
`default_nettype none

module osd_char_ram (
    input  logic                                clk,
    input  logic [osd_reg_pkg::RAM_ADDR_W-1:0]  ram_waddr,
    input  logic [osd_reg_pkg::DATA_W-1:0]      ram_wdata,
    input  logic                                ram_we,
    input  logic [osd_reg_pkg::RAM_ADDR_W-1:0]  osd_rd_addr,
    output logic [osd_reg_pkg::DATA_W-1:0]      osd_rd_data
);

    // 1024 characters
    logic [osd_reg_pkg::DATA_W-1:0] mem [0:(1 << osd_reg_pkg::RAM_ADDR_W)-1];

    // host port, write only
    always_ff @(posedge clk) begin
        if (ram_we) begin
            mem[ram_waddr] <= ram_wdata;
        end
    end

    // display port, one cycle read latency
    always_ff @(posedge clk) begin
        osd_rd_data <= mem[osd_rd_addr];
    end

endmodule

`default_nettype wire

//--- rtl/osd_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module osd_reg_file (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [osd_reg_pkg::ADDR_W-1:0]      reg_addr,
    input  logic [osd_reg_pkg::DATA_W-1:0]      reg_wdata,
    input  logic                                wr_strobe,
    input  logic                                rd_strobe,
    input  logic [12:0]                         ctrl_buttons,
    input  logic                                ctrl_valid,
    input  logic                                add_line,
    input  logic                                line_doubler,
    input  logic                                is_pal,
    input  logic [23:0]                         pinok,
    input  logic [23:0]                         timing_info,
    input  logic [23:0]                         rgb_data,
    output logic [osd_reg_pkg::DATA_W-1:0]      rd_data,
    output logic [osd_reg_pkg::RAM_ADDR_W-1:0]  ram_waddr,
    output logic [osd_reg_pkg::DATA_W-1:0]      ram_wdata,
    output logic                                ram_we,
    output logic                                osd_enable,
    output logic [7:0]                          highlight_line,
    output logic [osd_reg_pkg::RECONF_W-1:0]    reconf_code,
    output logic                                reconf_load,
    output logic [7:0]                          video_gen_data,
    output logic [8:0]                          scan_intensity,
    output logic                                scan_thickness,
    output logic                                scan_oddeven,
    output logic                                scan_active,
    output logic [7:0]                          conf240p,
    output logic                                reset_dc,
    output logic                                reset_opt,
    output logic [7:0]                          reset_conf
);

    // page offset for the text window
    logic [2:0] osd_page;
    logic       wr_text;

    // host writes below 0x80 land in the character memory
    assign wr_text = wr_strobe && !reg_addr[7];

    ////////////////////////////////////////////////////////////////////////////
    // write path
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            osd_page       <= '0;
            osd_enable     <= 1'b0;
            highlight_line <= osd_reg_pkg::HIGHLIGHT_RST;
            // code that selects 1080p, matches the mode table reset
            reconf_code    <= video_mode_pkg::CODE_GRP_480P;
            video_gen_data <= '0;
            scan_intensity <= osd_reg_pkg::SCAN_INTENSITY_RST;
            scan_thickness <= 1'b0;
            scan_oddeven   <= 1'b0;
            scan_active    <= 1'b0;
            conf240p       <= osd_reg_pkg::CONF240P_RST;
            reset_conf     <= '0;
        end else if (wr_strobe) begin
            case (reg_addr)
                osd_reg_pkg::ADDR_OSD_PAGE:   osd_page       <= reg_wdata[2:0];
                osd_reg_pkg::ADDR_OSD_ENABLE: osd_enable     <= reg_wdata[0];
                osd_reg_pkg::ADDR_HIGHLIGHT:  highlight_line <= reg_wdata;
                // top bit of the byte is not part of the code
                osd_reg_pkg::ADDR_RECONF:     reconf_code    <= reg_wdata[6:0];
                osd_reg_pkg::ADDR_VIDEO_GEN:  video_gen_data <= reg_wdata;
                // intensity msbs
                osd_reg_pkg::ADDR_SCAN_HI:    scan_intensity[8:1] <= reg_wdata;
                osd_reg_pkg::ADDR_SCAN_LO: begin
                    scan_intensity[0] <= reg_wdata[7];
                    scan_thickness    <= reg_wdata[6];
                    scan_oddeven      <= reg_wdata[5];
                    scan_active       <= reg_wdata[4];
                end
                osd_reg_pkg::ADDR_CONF240P:   conf240p   <= reg_wdata;
                osd_reg_pkg::ADDR_RESET_CONF: reset_conf <= reg_wdata;
                default: ;
            endcase
        end
    end

    // single-cycle pulses, one cycle after the strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ram_we      <= 1'b0;
            reconf_load <= 1'b0;
            reset_dc    <= 1'b0;
            reset_opt   <= 1'b0;
        end else begin
            ram_we      <= wr_text;
            reconf_load <= wr_strobe && (reg_addr == osd_reg_pkg::ADDR_RECONF);
            reset_dc    <= wr_strobe && (reg_addr == osd_reg_pkg::ADDR_RESET_DC);
            reset_opt   <= wr_strobe && (reg_addr == osd_reg_pkg::ADDR_RESET_OPT);
        end
    end

    // memory address and data ride along with ram_we
    always_ff @(posedge clk) begin
        if (wr_text) begin
            ram_waddr <= {osd_page, reg_addr[6:0]};
            ram_wdata <= reg_wdata;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read mux, captured on the request edge
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rd_strobe) begin
            case (reg_addr)
                osd_reg_pkg::ADDR_OSD_PAGE:   rd_data <= {5'b0, osd_page};
                osd_reg_pkg::ADDR_OSD_ENABLE: rd_data <= {7'b0, osd_enable};
                osd_reg_pkg::ADDR_HIGHLIGHT:  rd_data <= highlight_line;
                osd_reg_pkg::ADDR_RECONF:     rd_data <= {1'b0, reconf_code};
                osd_reg_pkg::ADDR_VIDEO_GEN:  rd_data <= video_gen_data;
                // a b x y up down left right
                osd_reg_pkg::ADDR_CTRL_HI:    rd_data <= ctrl_buttons[12:5];
                // start, triggers, osd and default-res keys, valid in bit 0
                osd_reg_pkg::ADDR_CTRL_LO: begin
                    rd_data <= {ctrl_buttons[4:0], 2'b00, ctrl_valid};
                end
                osd_reg_pkg::ADDR_LINE_FLAGS: begin
                    rd_data <= {add_line, line_doubler, is_pal, 5'b0};
                end
                osd_reg_pkg::ADDR_SCAN_HI:    rd_data <= scan_intensity[8:1];
                osd_reg_pkg::ADDR_SCAN_LO: begin
                    rd_data <= {scan_intensity[0], scan_thickness, scan_oddeven,
                                scan_active, 4'b0};
                end
                osd_reg_pkg::ADDR_CONF240P:   rd_data <= conf240p;
                // only 22 pin checks exist
                osd_reg_pkg::ADDR_PINOK0:          rd_data <= {2'b0, pinok[21:16]};
                osd_reg_pkg::ADDR_PINOK0 + 8'd1:   rd_data <= pinok[15:8];
                osd_reg_pkg::ADDR_PINOK0 + 8'd2:   rd_data <= pinok[7:0];
                osd_reg_pkg::ADDR_TIMING0:         rd_data <= timing_info[23:16];
                osd_reg_pkg::ADDR_TIMING0 + 8'd1:  rd_data <= timing_info[15:8];
                osd_reg_pkg::ADDR_TIMING0 + 8'd2:  rd_data <= timing_info[7:0];
                // red, green, blue
                osd_reg_pkg::ADDR_RGB0:            rd_data <= rgb_data[23:16];
                osd_reg_pkg::ADDR_RGB0 + 8'd1:     rd_data <= rgb_data[15:8];
                osd_reg_pkg::ADDR_RGB0 + 8'd2:     rd_data <= rgb_data[7:0];
                default:                           rd_data <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/wb_reg_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module wb_reg_bridge (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             cyc,
    input  logic                             stb,
    input  logic                             we,
    input  logic [osd_reg_pkg::ADDR_W-1:0]   adr,
    input  logic [osd_reg_pkg::DATA_W-1:0]   dat_w,
    input  logic [osd_reg_pkg::DATA_W-1:0]   rd_data,
    output logic                             ack,
    output logic [osd_reg_pkg::DATA_W-1:0]   dat_r,
    output logic [osd_reg_pkg::ADDR_W-1:0]   reg_addr,
    output logic [osd_reg_pkg::DATA_W-1:0]   reg_wdata,
    output logic                             wr_strobe,
    output logic                             rd_strobe
);

    osd_reg_pkg::bridge_state_e state;
    osd_reg_pkg::bridge_state_e state_next;
    logic req;

    // new request only while idle
    assign req = cyc && stb && (state == osd_reg_pkg::IDLE);

    // address and data go straight through
    assign reg_addr  = adr;
    assign reg_wdata = dat_w;

    // one-cycle strobes on the accepting edge
    assign wr_strobe = req && we;
    assign rd_strobe = req && !we;

    always_comb begin
        state_next = state;
        case (state)
            osd_reg_pkg::IDLE: begin
                if (cyc && stb) begin
                    state_next = osd_reg_pkg::ACK;
                end
            end
            // ack lasts one cycle, back to idle
            osd_reg_pkg::ACK: begin
                state_next = osd_reg_pkg::IDLE;
            end
            default: begin
                state_next = osd_reg_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= osd_reg_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ack is the state flop itself
    assign ack = (state == osd_reg_pkg::ACK);

    // read data captured by the register file on the request edge
    assign dat_r = ack ? rd_data : '0;

endmodule

`default_nettype wire

//--- rtl/video_mode_pkg.sv
`default_nettype none

package video_mode_pkg;

    // output modes; 240P variants sit at 4..7, same order as the direct modes
    typedef enum logic [3:0] {
        MODE_1080P      = 4'd0,
        MODE_960P       = 4'd1,
        MODE_480P       = 4'd2,
        MODE_VGA        = 4'd3,
        MODE_240P_1080P = 4'd4,
        MODE_240P_960P  = 4'd5,
        MODE_240P_480P  = 4'd6,
        MODE_240P_VGA   = 4'd7,
        MODE_480I       = 4'd8,
        MODE_576I       = 4'd9
    } video_mode_e;

    // timing word widths
    localparam int H_ACTIVE_W = 12;
    localparam int V_ACTIVE_W = 11;

    ////////////////////////////////////////////////////////////////////////////
    // active area per output resolution
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [H_ACTIVE_W-1:0] H_1080P = 12'd1920;
    localparam logic [V_ACTIVE_W-1:0] V_1080P = 11'd1080;
    localparam logic [H_ACTIVE_W-1:0] H_960P  = 12'd1280;
    localparam logic [V_ACTIVE_W-1:0] V_960P  = 11'd960;
    localparam logic [H_ACTIVE_W-1:0] H_480P  = 12'd720;
    localparam logic [V_ACTIVE_W-1:0] V_480P  = 11'd480;
    localparam logic [H_ACTIVE_W-1:0] H_VGA   = 12'd640;
    localparam logic [V_ACTIVE_W-1:0] V_VGA   = 11'd480;
    // interlaced, full frame height
    localparam logic [H_ACTIVE_W-1:0] H_480I  = 12'd720;
    localparam logic [V_ACTIVE_W-1:0] V_480I  = 11'd480;
    localparam logic [H_ACTIVE_W-1:0] H_576I  = 12'd720;
    localparam logic [V_ACTIVE_W-1:0] V_576I  = 11'd576;

    // reconfiguration code groups
    // 0x0x and 0x1x pick by the low two bits, 0x2x and 0x4x ignore them
    localparam logic [6:0] CODE_GRP_480P = 7'h00;
    localparam logic [6:0] CODE_GRP_240P = 7'h10;
    localparam logic [6:0] CODE_GRP_480I = 7'h20;
    localparam logic [6:0] CODE_GRP_576I = 7'h40;

endpackage

`default_nettype wire

//--- rtl/osd_reg_pkg.sv
`default_nettype none

package osd_reg_pkg;

    // host bus widths
    localparam int ADDR_W = 8;
    localparam int DATA_W = 8;

    // character memory, 8 pages of 128 bytes
    localparam int RAM_ADDR_W = 10;

    // mode reconfiguration field
    localparam int RECONF_W = 7;

    ////////////////////////////////////////////////////////////////////////////
    // register map
    ////////////////////////////////////////////////////////////////////////////

    // below 0x80 is the OSD text window
    localparam logic [ADDR_W-1:0] ADDR_OSD_PAGE   = 8'h80;
    localparam logic [ADDR_W-1:0] ADDR_OSD_ENABLE = 8'h81;
    localparam logic [ADDR_W-1:0] ADDR_HIGHLIGHT  = 8'h82;
    localparam logic [ADDR_W-1:0] ADDR_RECONF     = 8'h83;
    localparam logic [ADDR_W-1:0] ADDR_VIDEO_GEN  = 8'h84;
    // controller buttons, two bytes
    localparam logic [ADDR_W-1:0] ADDR_CTRL_HI    = 8'h85;
    localparam logic [ADDR_W-1:0] ADDR_CTRL_LO    = 8'h86;
    localparam logic [ADDR_W-1:0] ADDR_LINE_FLAGS = 8'h87;
    // scanline fields
    localparam logic [ADDR_W-1:0] ADDR_SCAN_HI    = 8'h88;
    localparam logic [ADDR_W-1:0] ADDR_SCAN_LO    = 8'h89;
    localparam logic [ADDR_W-1:0] ADDR_CONF240P   = 8'h90;
    // status words, three bytes each, msb first
    localparam logic [ADDR_W-1:0] ADDR_PINOK0     = 8'hB0;
    localparam logic [ADDR_W-1:0] ADDR_TIMING0    = 8'hB3;
    localparam logic [ADDR_W-1:0] ADDR_RGB0       = 8'hB6;
    // write-only pulses and reset config
    localparam logic [ADDR_W-1:0] ADDR_RESET_DC   = 8'hF0;
    localparam logic [ADDR_W-1:0] ADDR_RESET_OPT  = 8'hF1;
    localparam logic [ADDR_W-1:0] ADDR_RESET_CONF = 8'hF2;

    // reset values
    localparam logic [DATA_W-1:0] HIGHLIGHT_RST      = 8'hFF;
    localparam logic [8:0]        SCAN_INTENSITY_RST = 9'h100;
    localparam logic [DATA_W-1:0] CONF240P_RST       = 8'd20;

    // bus bridge FSM
    typedef enum logic {
        IDLE = 1'b0,
        ACK  = 1'b1
    } bridge_state_e;

endpackage

`default_nettype wire
